// File: hdl/ldpc_enc_cfg.svh
// ldpc encoder input side, build configuration
// stream widths, bank depth and AXI4-Lite register map
`ifndef LDPC_ENC_CFG_SVH
`define LDPC_ENC_CFG_SVH

// input byte width
`define LDPC_DAT_W    8
// buffer word width, a whole multiple of the byte width
`define LDPC_WDAT_W   32
// word address width, 32 words per bank
`define LDPC_WADDR_W  5

// ----------------------------------------------------------------------
// register map
// ----------------------------------------------------------------------
`define LDPC_AXI_AW      4
`define LDPC_REG_CTRL    'h0
`define LDPC_REG_STATUS  'h4
`define LDPC_REG_FRAMES  'h8
`define LDPC_REG_CHECK   'hC

`endif

// File: hdl/ldpc_enc_pingpong_buf.sv
// ldpc encoder ping-pong frame buffer
// two banks of words with full flags and stored frame lengths,
// registered read port
`default_nettype none

`include "ldpc_enc_cfg.svh"

module ldpc_enc_pingpong_buf (
  input  logic                     iclk,
  input  logic                     ireset,
  input  ldpc_enc_pkg::buf_wr_t    wr,
  output ldpc_enc_pkg::buf_state_t state,
  input  logic [`LDPC_WADDR_W-1:0] rd_addr,
  input  logic                     rd_release,
  output logic                     rd_full,
  output logic [`LDPC_WADDR_W:0]   rd_len,
  output logic [`LDPC_WDAT_W-1:0]  rd_data
);

  localparam int depth = 1 << `LDPC_WADDR_W;  // words per bank

  logic [`LDPC_WDAT_W-1:0] mem [0:2*depth-1];  // bank bit on top
  logic [`LDPC_WADDR_W:0]  len [0:1];          // words per stored frame
  logic [1:0]              full;
  logic                    wbank;
  logic                    rbank;

  // ----------------------------------------------------------------------
  // bank flags
  // ----------------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      full  <= '0;
      wbank <= 1'b0;
      rbank <= 1'b0;
    end else begin
      if (wr.wfull) begin
        full[wbank] <= 1'b1;
        wbank       <= ~wbank;
      end
      // release always targets the other bank, it is full
      if (rd_release) begin
        full[rbank] <= 1'b0;
        rbank       <= ~rbank;
      end
    end
  end

  // ----------------------------------------------------------------------
  // storage
  // ----------------------------------------------------------------------
  always_ff @(posedge iclk) begin
    if (wr.write)
      mem[{wbank, wr.waddr}] <= wr.wdat;
    if (wr.wfull)
      len[wbank] <= {1'b0, wr.waddr} + 1'b1;  // last address plus one
    rd_data <= mem[{rbank, rd_addr}];        // one cycle latency
  end

  assign rd_full = full[rbank];
  assign rd_len  = len[rbank];

  assign state = '{fulla: &full, emptya: ~|full};

endmodule

`default_nettype wire

// File: hdl/ldpc_enc_pkg.sv
// ldpc encoder input side, shared types
// stream beats, buffer write port and buffer state flags
`default_nettype none

`include "ldpc_enc_cfg.svh"

package ldpc_enc_pkg;

  // input byte beat
  typedef struct packed {
    logic                     sop;
    logic                     eop;
    logic                     val;
    logic [`LDPC_DAT_W-1:0]   dat;
  } byte_beat_t;

  // output word beat, valid travels beside it
  typedef struct packed {
    logic                     sop;
    logic                     eop;
    logic [`LDPC_WDAT_W-1:0]  dat;
  } word_beat_t;

  // source -> buffer write port
  typedef struct packed {
    logic                     write;  // store wdat at waddr
    logic                     wfull;  // close the bank, one cycle
    logic [`LDPC_WADDR_W-1:0] waddr;
    logic [`LDPC_WDAT_W-1:0]  wdat;
  } buf_wr_t;

  // buffer flags
  typedef struct packed {
    logic                     fulla;   // both banks full
    logic                     emptya;  // both banks empty
  } buf_state_t;

endpackage

`default_nettype wire

// File: hdl/ldpc_enc_regs.sv
// ldpc encoder control registers, AXI4-Lite slave
// CTRL enable and counter clear, STATUS flags, output frame count
// and last check word
`default_nettype none

`include "ldpc_enc_cfg.svh"

module ldpc_enc_regs (
  input  logic                    iclk,
  input  logic                    ireset,
  // write address / data / response
  input  logic [`LDPC_AXI_AW-1:0] s_axi_awaddr,
  input  logic                    s_axi_awvalid,
  output logic                    s_axi_awready,
  input  logic [31:0]             s_axi_wdata,
  input  logic                    s_axi_wvalid,
  output logic                    s_axi_wready,
  output logic [1:0]              s_axi_bresp,
  output logic                    s_axi_bvalid,
  input  logic                    s_axi_bready,
  // read address / data
  input  logic [`LDPC_AXI_AW-1:0] s_axi_araddr,
  input  logic                    s_axi_arvalid,
  output logic                    s_axi_arready,
  output logic [31:0]             s_axi_rdata,
  output logic [1:0]              s_axi_rresp,
  output logic                    s_axi_rvalid,
  input  logic                    s_axi_rready,
  // datapath side
  input  logic                    in_rdy,
  input  logic                    busy,
  input  logic                    frame_done,
  input  logic [`LDPC_WDAT_W-1:0] frame_check,
  output logic                    enable
);

  logic                    aw_got;   // address held, waiting for data
  logic                    w_got;    // data held, waiting for address
  logic [`LDPC_AXI_AW-1:0] aw_addr;
  logic [31:0]             w_data;
  logic [`LDPC_AXI_AW-1:0] wr_addr;  // address of the write in progress
  logic [31:0]             wr_data;
  logic                    do_write;
  logic                    clr_frames;
  logic [31:0]             frames;
  logic [`LDPC_WDAT_W-1:0] check_q;

  // ----------------------------------------------------------------------
  // write channel
  // ----------------------------------------------------------------------
  assign s_axi_awready = !aw_got & !s_axi_bvalid;
  assign s_axi_wready  = !w_got & !s_axi_bvalid;
  assign s_axi_bresp   = 2'b00;  // OKAY

  assign wr_addr  = aw_got ? aw_addr : s_axi_awaddr;
  assign wr_data  = w_got ? w_data : s_axi_wdata;
  assign do_write = (aw_got | (s_axi_awvalid & s_axi_awready)) &
                    (w_got | (s_axi_wvalid & s_axi_wready));
  assign clr_frames = do_write & (wr_addr == `LDPC_REG_CTRL) & wr_data[1];

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      aw_got       <= 1'b0;
      w_got        <= 1'b0;
      s_axi_bvalid <= 1'b0;
      enable       <= 1'b0;
    end else begin
      if (do_write) begin
        aw_got       <= 1'b0;
        w_got        <= 1'b0;
        s_axi_bvalid <= 1'b1;  // response next cycle
        if (wr_addr == `LDPC_REG_CTRL)
          enable <= wr_data[0];
      end else begin
        aw_got <= aw_got | (s_axi_awvalid & s_axi_awready);
        w_got  <= w_got | (s_axi_wvalid & s_axi_wready);
        if (s_axi_bready)
          s_axi_bvalid <= 1'b0;
      end
    end
  end

  // holding registers for a split address/data arrival
  always_ff @(posedge iclk) begin
    if (s_axi_awvalid & s_axi_awready)
      aw_addr <= s_axi_awaddr;
    if (s_axi_wvalid & s_axi_wready)
      w_data <= s_axi_wdata;
  end

  // ----------------------------------------------------------------------
  // frame counter and check word
  // ----------------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      frames  <= '0;
      check_q <= '0;
    end else begin
      if (clr_frames)
        frames <= '0;  // clear beats a coincident frame
      else if (frame_done)
        frames <= frames + 1'b1;
      if (frame_done)
        check_q <= frame_check;
    end
  end

  // ----------------------------------------------------------------------
  // read channel
  // ----------------------------------------------------------------------
  assign s_axi_arready = !s_axi_rvalid;
  assign s_axi_rresp   = 2'b00;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      s_axi_rvalid <= 1'b0;
      s_axi_rdata  <= '0;
    end else if (s_axi_arvalid & s_axi_arready) begin
      s_axi_rvalid <= 1'b1;
      case (s_axi_araddr)
        `LDPC_REG_CTRL:   s_axi_rdata <= {31'b0, enable};  // clear bit reads 0
        `LDPC_REG_STATUS: s_axi_rdata <= {30'b0, busy, in_rdy};
        `LDPC_REG_FRAMES: s_axi_rdata <= frames;
        `LDPC_REG_CHECK:  s_axi_rdata <= 32'(check_q);
        default:          s_axi_rdata <= '0;  // unmapped
      endcase
    end else if (s_axi_rready) begin
      s_axi_rvalid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/ldpc_enc_source.sv
// ldpc encoder byte source
// packs bytes into buffer words lsb first, addresses the frame
// and closes the bank after eop
`default_nettype none

`include "ldpc_enc_cfg.svh"

module ldpc_enc_source (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     enable,
  input  ldpc_enc_pkg::byte_beat_t in_beat,
  input  ldpc_enc_pkg::buf_state_t state,
  output logic                     in_rdy,
  output logic                     busy,
  output ldpc_enc_pkg::buf_wr_t    wr
);

  localparam int factor = `LDPC_WDAT_W / `LDPC_DAT_W;  // bytes per word
  localparam int cnt_w  = (factor > 1) ? $clog2(factor) : 1;

  typedef struct packed {
    logic             done;   // next byte completes the word
    logic [cnt_w-1:0] value;
  } dwc_cnt_t;

  dwc_cnt_t                 cnt;
  logic                     acc;      // byte accepted
  logic                     last;     // accepted byte closes a word
  logic                     write_q;
  logic                     wfull_q;
  logic [`LDPC_WADDR_W-1:0] waddr_q;
  logic [`LDPC_WDAT_W-1:0]  wdat_q;

  assign acc  = in_beat.val & in_rdy;
  assign last = (factor == 1) | (!in_beat.sop & cnt.done);  // sop byte never ends a word

  // ----------------------------------------------------------------------
  // byte counter and write strobes
  // ----------------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      write_q <= 1'b0;
      wfull_q <= 1'b0;
      cnt     <= '0;
    end else begin
      write_q <= acc & last;
      wfull_q <= acc & in_beat.eop;  // frame holds whole words
      if (acc) begin
        if (in_beat.sop) begin
          cnt.value <= cnt_w'(1);
          cnt.done  <= (factor <= 2);
        end else begin
          cnt.value <= cnt.done ? '0 : cnt.value + 1'b1;
          cnt.done  <= (cnt.value == cnt_w'(factor - 2));
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // word register and frame address
  // ----------------------------------------------------------------------
  always_ff @(posedge iclk) begin
    if (acc) begin
      // shift down, new byte enters at the top
      wdat_q <= (wdat_q >> `LDPC_DAT_W) |
                (`LDPC_WDAT_W'(in_beat.dat) << (`LDPC_WDAT_W - `LDPC_DAT_W));
    end
    if (acc & in_beat.sop)
      waddr_q <= '0;  // new frame
    else
      waddr_q <= waddr_q + `LDPC_WADDR_W'(write_q);  // step after each write
  end

  assign wr = '{write: write_q, wfull: wfull_q, waddr: waddr_q, wdat: wdat_q};

  // stall while closing a bank or with no free bank
  assign in_rdy = enable & !wfull_q & !state.fulla;
  assign busy   = wfull_q | !state.emptya;  // some bank still holds data

endmodule

`default_nettype wire

// File: hdl/ldpc_enc_top.sv
// ldpc encoder input side, top level
// byte source, ping-pong buffer, xor reader and AXI4-Lite registers
`default_nettype none

`include "ldpc_enc_cfg.svh"

module ldpc_enc_top (
  input  logic                     iclk,
  input  logic                     ireset,
  // byte stream in
  input  ldpc_enc_pkg::byte_beat_t in_beat,
  output logic                     in_rdy,
  // word stream out
  output ldpc_enc_pkg::word_beat_t out_beat,
  output logic                     out_valid,
  input  logic                     out_ready,
  // AXI4-Lite
  input  logic [`LDPC_AXI_AW-1:0]  s_axi_awaddr,
  input  logic                     s_axi_awvalid,
  output logic                     s_axi_awready,
  input  logic [31:0]              s_axi_wdata,
  input  logic                     s_axi_wvalid,
  output logic                     s_axi_wready,
  output logic [1:0]               s_axi_bresp,
  output logic                     s_axi_bvalid,
  input  logic                     s_axi_bready,
  input  logic [`LDPC_AXI_AW-1:0]  s_axi_araddr,
  input  logic                     s_axi_arvalid,
  output logic                     s_axi_arready,
  output logic [31:0]              s_axi_rdata,
  output logic [1:0]               s_axi_rresp,
  output logic                     s_axi_rvalid,
  input  logic                     s_axi_rready
);

  logic                     enable;
  logic                     busy;
  ldpc_enc_pkg::buf_wr_t    wr;
  ldpc_enc_pkg::buf_state_t state;
  logic [`LDPC_WADDR_W-1:0] rd_addr;
  logic                     rd_release;
  logic                     rd_full;
  logic [`LDPC_WADDR_W:0]   rd_len;
  logic [`LDPC_WDAT_W-1:0]  rd_data;
  logic                     frame_done;
  logic [`LDPC_WDAT_W-1:0]  frame_check;

  ldpc_enc_regs u_regs (
    .iclk          (iclk),
    .ireset        (ireset),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .in_rdy        (in_rdy),
    .busy          (busy),
    .frame_done    (frame_done),
    .frame_check   (frame_check),
    .enable        (enable)
  );

  ldpc_enc_source u_source (
    .iclk    (iclk),
    .ireset  (ireset),
    .enable  (enable),
    .in_beat (in_beat),
    .state   (state),
    .in_rdy  (in_rdy),
    .busy    (busy),
    .wr      (wr)
  );

  ldpc_enc_pingpong_buf u_buf (
    .iclk       (iclk),
    .ireset     (ireset),
    .wr         (wr),
    .state      (state),
    .rd_addr    (rd_addr),
    .rd_release (rd_release),
    .rd_full    (rd_full),
    .rd_len     (rd_len),
    .rd_data    (rd_data)
  );

  ldpc_enc_xor_reader u_reader (
    .iclk        (iclk),
    .ireset      (ireset),
    .rd_full     (rd_full),
    .rd_len      (rd_len),
    .rd_data     (rd_data),
    .rd_addr     (rd_addr),
    .rd_release  (rd_release),
    .out_beat    (out_beat),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .frame_done  (frame_done),
    .frame_check (frame_check)
  );

endmodule

`default_nettype wire

// File: hdl/ldpc_enc_xor_reader.sv
// ldpc encoder bank reader
// drains a full bank as a valid/ready word stream and closes the
// frame with the xor of its words, standing in for the parity core
`default_nettype none

`include "ldpc_enc_cfg.svh"

module ldpc_enc_xor_reader (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     rd_full,
  input  logic [`LDPC_WADDR_W:0]   rd_len,
  input  logic [`LDPC_WDAT_W-1:0]  rd_data,
  output logic [`LDPC_WADDR_W-1:0] rd_addr,
  output logic                     rd_release,
  output ldpc_enc_pkg::word_beat_t out_beat,
  output logic                     out_valid,
  input  logic                     out_ready,
  output logic                     frame_done,
  output logic [`LDPC_WDAT_W-1:0]  frame_check
);

  typedef enum logic [1:0] {
    st_idle,
    st_fetch,  // wait out the read latency
    st_data,
    st_check
  } state_t;

  state_t                   st;
  logic                     xfer;      // word taken downstream
  logic                     load;      // rd_data moves into the output
  logic                     last_dat;  // last data word is on the output
  logic [`LDPC_WADDR_W-1:0] addr_q;    // address held in rd_data
  logic [`LDPC_WADDR_W:0]   cnt;       // data words loaded
  logic [`LDPC_WDAT_W-1:0]  acc;       // running xor

  assign xfer     = out_valid & out_ready;
  assign last_dat = (cnt == rd_len);
  assign load     = (st == st_fetch) | ((st == st_data) & xfer & !last_dat);

  // prefetch, the next address goes out as soon as rd_data is taken
  assign rd_addr = addr_q + `LDPC_WADDR_W'(load);

  // ----------------------------------------------------------------------
  // fsm and output register
  // ----------------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      st        <= st_idle;
      out_valid <= 1'b0;
      addr_q    <= '0;
      cnt       <= '0;
    end else begin
      addr_q <= rd_addr;
      case (st)
        st_idle: if (rd_full) st <= st_fetch;
        st_fetch: begin
          out_valid <= 1'b1;
          cnt       <= {{`LDPC_WADDR_W{1'b0}}, 1'b1};
          st        <= st_data;
        end
        st_data: begin
          if (xfer & !last_dat)
            cnt <= cnt + 1'b1;
          else if (xfer)
            st <= st_check;  // check word loaded below
        end
        st_check: begin
          if (xfer) begin
            out_valid <= 1'b0;
            addr_q    <= '0;  // next bank starts at zero
            st        <= st_idle;
          end
        end
        default: st <= st_idle;
      endcase
    end
  end

  // payload, no reset
  always_ff @(posedge iclk) begin
    if (st == st_fetch) begin
      out_beat <= '{sop: 1'b1, eop: 1'b0, dat: rd_data};
      acc      <= '0;
    end else if ((st == st_data) & xfer) begin
      acc <= acc ^ out_beat.dat;  // fold every transferred word
      if (last_dat)
        out_beat <= '{sop: 1'b0, eop: 1'b1, dat: acc ^ out_beat.dat};
      else
        out_beat <= '{sop: 1'b0, eop: 1'b0, dat: rd_data};
    end
  end

  // check word handshake frees the bank
  assign rd_release  = (st == st_check) & xfer;
  assign frame_done  = rd_release;
  assign frame_check = out_beat.dat;

endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/ldpc_enc_pkg.sv
hdl/ldpc_enc_source.sv
hdl/ldpc_enc_pingpong_buf.sv
hdl/ldpc_enc_xor_reader.sv
hdl/ldpc_enc_regs.sv
hdl/ldpc_enc_top.sv
test/tb_ldpc_enc_top.sv

// File: test/tb_ldpc_enc_top.sv
// ldpc encoder input side, directed testbench
// byte frames in, word frames plus xor check word out,
// AXI4-Lite register access and a watchdog
`default_nettype none

`include "ldpc_enc_cfg.svh"

module tb_ldpc_enc_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int factor    = `LDPC_WDAT_W / `LDPC_DAT_W;  // bytes per word
  localparam int max_bytes = (1 << `LDPC_WADDR_W) * factor;
  localparam int max_words = 8 + 4 + 6 + 5 * 12 + 4;      // all frames, upper bound
  localparam int wd_cycles = 200 * max_words + 2000;

  logic                     iclk = 1'b0;
  logic                     ireset;
  ldpc_enc_pkg::byte_beat_t in_beat;
  logic                     in_rdy;
  ldpc_enc_pkg::word_beat_t out_beat;
  logic                     out_valid;
  logic                     out_ready;
  logic [`LDPC_AXI_AW-1:0]  awaddr;
  logic [`LDPC_AXI_AW-1:0]  araddr;
  logic                     awvalid;
  logic                     awready;
  logic                     wvalid;
  logic                     wready;
  logic                     bvalid;
  logic                     bready;
  logic                     arvalid;
  logic                     arready;
  logic                     rvalid;
  logic                     rready;
  logic [31:0]              wdata;
  logic [31:0]              rdata;
  logic [1:0]               bresp;
  logic [1:0]               rresp;

  // frame store for the model, one row per frame
  logic [`LDPC_DAT_W-1:0]   frame_mem [0:8][0:max_bytes-1];
  int                       frame_nb [0:8];
  logic [`LDPC_WDAT_W-1:0]  last_check;
  int                       frames_out;
  int                       n_checks;
  int                       n_errors;
  string                    cur_test;

  ldpc_enc_top u_dut (
    .iclk (iclk), .ireset (ireset),
    .in_beat (in_beat), .in_rdy (in_rdy),
    .out_beat (out_beat), .out_valid (out_valid), .out_ready (out_ready),
    .s_axi_awaddr (awaddr), .s_axi_awvalid (awvalid), .s_axi_awready (awready),
    .s_axi_wdata (wdata), .s_axi_wvalid (wvalid), .s_axi_wready (wready),
    .s_axi_bresp (bresp), .s_axi_bvalid (bvalid), .s_axi_bready (bready),
    .s_axi_araddr (araddr), .s_axi_arvalid (arvalid), .s_axi_arready (arready),
    .s_axi_rdata (rdata), .s_axi_rresp (rresp), .s_axi_rvalid (rvalid),
    .s_axi_rready (rready)
  );

  always #5 iclk = ~iclk;  // 10 ns period

  // ----------------------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------------------
  task automatic check_word(input string what, input ldpc_enc_pkg::word_beat_t exp,
                            input ldpc_enc_pkg::word_beat_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("CHECK FAILED %s %s: expected sop %b eop %b dat %h, actual sop %b eop %b dat %h",
               cur_test, what, exp.sop, exp.eop, exp.dat, act.sop, act.eop, act.dat);
    end
  endtask

  task automatic check_reg(input string what, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("CHECK FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  // ----------------------------------------------------------------------
  // AXI4-Lite access, ready flags are registered so a negedge look holds
  // ----------------------------------------------------------------------
  task automatic axi_write(input logic [`LDPC_AXI_AW-1:0] addr, input logic [31:0] data);
    logic aw_hs;
    logic w_hs;
    @(negedge iclk);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    while (awvalid || wvalid) begin
      aw_hs = awvalid & awready;  // taken on the coming posedge
      w_hs  = wvalid & wready;
      @(negedge iclk);
      if (aw_hs) awvalid = 1'b0;
      if (w_hs) wvalid = 1'b0;
    end
    while (!bvalid) @(negedge iclk);
    check_reg("bresp", 32'h0, 32'(bresp));
    @(negedge iclk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [`LDPC_AXI_AW-1:0] addr, output logic [31:0] data);
    @(negedge iclk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    while (!arready) @(negedge iclk);
    @(negedge iclk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge iclk);
    data = rdata;
    check_reg("rresp", 32'h0, 32'(rresp));
    @(negedge iclk);
    rready = 1'b0;
  endtask

  task automatic read_expect(input string what, input logic [`LDPC_AXI_AW-1:0] addr,
                             input logic [31:0] exp);
    logic [31:0] val;
    axi_read(addr, val);
    check_reg(what, exp, val);
  endtask

  // ----------------------------------------------------------------------
  // stream side and model
  // ----------------------------------------------------------------------
  task automatic make_frame(input int f, input int nwords);
    int i;
    frame_nb[f] = nwords * factor;
    for (i = 0; i < frame_nb[f]; i++)
      frame_mem[f][i] = `LDPC_DAT_W'($urandom);
  endtask

  // first byte lands in the low bits
  function automatic logic [`LDPC_WDAT_W-1:0] pack_word(input int f, input int k);
    logic [`LDPC_WDAT_W-1:0] w;
    int j;
    w = '0;
    for (j = 0; j < factor; j++)
      w = w | (`LDPC_WDAT_W'(frame_mem[f][k * factor + j]) << (j * `LDPC_DAT_W));
    return w;
  endfunction

  task automatic send_frame(input int f);
    int i;
    int n;
    n = frame_nb[f];
    for (i = 0; i < n; i++) begin
      @(negedge iclk);
      in_beat = '0;
      while (!in_rdy) @(negedge iclk);  // in_rdy holds until the posedge
      in_beat = '{sop: (i == 0), eop: (i == n - 1), val: 1'b1, dat: frame_mem[f][i]};
    end
    @(negedge iclk);
    in_beat = '0;
  endtask

  task automatic expect_frame(input int f, input int ready_pct);
    ldpc_enc_pkg::word_beat_t exp;
    logic [`LDPC_WDAT_W-1:0]  chk;
    int                       nw;
    int                       idx;
    nw  = frame_nb[f] / factor;
    chk = '0;
    idx = 0;
    while (idx <= nw) begin
      @(negedge iclk);
      out_ready = (($urandom % 100) < ready_pct);
      if (out_valid && out_ready) begin  // transfer on the coming posedge
        if (idx < nw) begin
          exp = '{sop: (idx == 0), eop: 1'b0, dat: pack_word(f, idx)};
          chk = chk ^ exp.dat;
        end else begin
          exp = '{sop: 1'b0, eop: 1'b1, dat: chk};  // check word
        end
        check_word($sformatf("frame %0d word %0d", f, idx), exp, out_beat);
        idx++;
      end
    end
    last_check = chk;
    frames_out++;
    @(negedge iclk);
    out_ready = 1'b0;
  endtask

  task automatic expect_idle(input int cycles);
    repeat (cycles) begin
      @(negedge iclk);
      out_ready = 1'b1;
      check_bit("in_rdy", 1'b0, in_rdy);
      check_bit("out_valid", 1'b0, out_valid);
    end
    out_ready = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------
  task automatic test_reset_regs();
    cur_test = "reset_regs";
    check_bit("in_rdy", 1'b0, in_rdy);
    check_bit("out_valid", 1'b0, out_valid);
    check_bit("awready", 1'b1, awready);
    check_bit("wready", 1'b1, wready);
    check_bit("arready", 1'b1, arready);
    check_bit("bvalid", 1'b0, bvalid);
    check_bit("rvalid", 1'b0, rvalid);
    read_expect("ctrl", `LDPC_REG_CTRL, 32'h0);
    read_expect("status", `LDPC_REG_STATUS, 32'h0);
    read_expect("frames", `LDPC_REG_FRAMES, 32'h0);
    read_expect("check", `LDPC_REG_CHECK, 32'h0);
    read_expect("unmapped", 'h2, 32'h0);
    axi_write(`LDPC_REG_CTRL, 32'h1);
    read_expect("status enabled", `LDPC_REG_STATUS, 32'h1);  // ready, not busy
  endtask

  task automatic test_single_frame();
    cur_test = "single_frame";
    make_frame(0, 8);
    send_frame(0);
    expect_frame(0, 100);
  endtask

  task automatic test_both_banks();
    cur_test = "both_banks";
    make_frame(1, 4);
    make_frame(2, 6);
    send_frame(1);
    send_frame(2);
    read_expect("status full", `LDPC_REG_STATUS, 32'h2);  // busy, in_rdy low
    check_bit("in_rdy", 1'b0, in_rdy);
    expect_frame(1, 100);
    expect_frame(2, 100);
  endtask

  task automatic test_backpressure();
    int fs;
    int fe;
    cur_test = "backpressure";
    for (fs = 3; fs < 8; fs++)
      make_frame(fs, 2 + ($urandom % 11));  // 2 to 12 words
    fork
      for (fs = 3; fs < 8; fs++) send_frame(fs);
      for (fe = 3; fe < 8; fe++) expect_frame(fe, 60);
    join
    repeat (5) begin
      @(negedge iclk);
      check_bit("no extra word", 1'b0, out_valid);
    end
  endtask

  task automatic test_counters();
    cur_test = "counters";
    read_expect("frames", `LDPC_REG_FRAMES, 32'(frames_out));
    read_expect("check", `LDPC_REG_CHECK, 32'(last_check));
    axi_write(`LDPC_REG_CTRL, 32'h3);  // keep enable, clear count
    read_expect("frames cleared", `LDPC_REG_FRAMES, 32'h0);
    read_expect("ctrl", `LDPC_REG_CTRL, 32'h1);
    frames_out = 0;
  endtask

  task automatic test_disable();
    cur_test = "disable";
    axi_write(`LDPC_REG_CTRL, 32'h0);
    make_frame(8, 4);
    // frame waits on in_rdy while the block is off
    fork
      send_frame(8);
      begin
        expect_idle(20);
        read_expect("status off", `LDPC_REG_STATUS, 32'h0);
        axi_write(`LDPC_REG_CTRL, 32'h1);
      end
    join
    expect_frame(8, 100);
    read_expect("frames", `LDPC_REG_FRAMES, 32'(frames_out));
    read_expect("check", `LDPC_REG_CHECK, 32'(last_check));
  endtask

  // watchdog
  initial begin
    repeat (wd_cycles) @(posedge iclk);
    $display("timeout: DUT made no progress within %0d cycles", wd_cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    void'($urandom(52));
    ireset     = 1'b1;
    in_beat    = '0;
    out_ready  = 1'b0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    frames_out = 0;
    last_check = '0;
    n_checks   = 0;
    n_errors   = 0;
    repeat (10) @(negedge iclk);
    ireset = 1'b0;
    test_reset_regs();
    test_single_frame();
    test_both_banks();
    test_backpressure();
    test_counters();
    test_disable();
    $display("done: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire
